// File: Makefile
TOP = tb_bradford

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: brad_defs.svh
`ifndef BRAD_DEFS_SVH
`define BRAD_DEFS_SVH

// ----------------------------------------------------------------------
// Q16.16 fixed-point format
// ----------------------------------------------------------------------
`define FIX_W       32
`define FRAC_BITS   16

// Saturation limits of a 32-bit signed value
`define FIX_MAX     32'sh7FFF_FFFF
`define FIX_MIN     32'sh8000_0000

// Cone responses and matrix elements are limited to +/-2.0
`define FIX_CLAMP   32'sh0002_0000

// Divisors with a smaller magnitude take the guarded path
`define DIV_MIN     32'sh0000_0080

// ----------------------------------------------------------------------
// Bradford forward matrix, XYZ to LMS, row-major
// ----------------------------------------------------------------------
`define BRAD_00     32'sh0000_E525
`define BRAD_01     32'sh0000_4433
`define BRAD_02     32'shFFFF_D6AE
`define BRAD_10     32'shFFFF_3FF3
`define BRAD_11     32'sh0001_B6A8
`define BRAD_12     32'sh0000_0965
`define BRAD_20     32'sh0000_09F5
`define BRAD_21     32'shFFFF_EE77
`define BRAD_22     32'sh0001_0794

// ----------------------------------------------------------------------
// Inverse Bradford matrix, LMS to XYZ, row-major
// ----------------------------------------------------------------------
`define BRAD_INV_00 32'sh0000_FCAC
`define BRAD_INV_01 32'shFFFF_DA5B
`define BRAD_INV_02 32'sh0000_28F3
`define BRAD_INV_10 32'sh0000_6EAC
`define BRAD_INV_11 32'sh0000_84B3
`define BRAD_INV_12 32'sh0000_0C9E
`define BRAD_INV_20 32'shFFFF_FDD1
`define BRAD_INV_21 32'sh0000_0A40
`define BRAD_INV_22 32'sh0000_F7EF

`endif

// File: brad_pkg.sv
`include "brad_defs.svh"

package brad_pkg;

    // One signed Q16.16 value
    typedef logic signed [`FIX_W-1:0] fix_t;

    // Full product of two fix_t values, also used as wide accumulator
    typedef logic signed [2*`FIX_W-1:0] prod_t;

    // 3x3 matrix, row-major, element 00 in the lowest word
    typedef logic [9*`FIX_W-1:0] mat_t;

    // ------------------------------------------------------------------
    // Fixed-point helpers
    // ------------------------------------------------------------------

    // Q16.16 multiply, arithmetic shift keeps the sign
    function automatic fix_t fix_mul(input fix_t a, input fix_t b);
        prod_t p;
        p = prod_t'(a) * prod_t'(b);
        return fix_t'(p >>> `FRAC_BITS);
    endfunction

    // Limit a wide value to +/-2.0
    function automatic fix_t fix_clamp(input prod_t v);
        prod_t hi;
        prod_t lo;
        hi = prod_t'(`FIX_CLAMP);
        lo = -hi;
        if (v > hi) begin
            return `FIX_CLAMP;
        end else if (v < lo) begin
            return -`FIX_CLAMP;
        end
        return fix_t'(v);
    endfunction

    // Q16.16 divide with a guard for tiny divisors
    function automatic fix_t fix_div(input fix_t num, input fix_t den);
        prod_t mag;
        prod_t quo;
        mag = (den < 0) ? -prod_t'(den) : prod_t'(den);
        if (mag < prod_t'(`DIV_MIN)) begin
            if (num == '0) begin
                return '0;
            end else if (num[`FIX_W-1] == den[`FIX_W-1]) begin
                return `FIX_MAX;
            end
            return `FIX_MIN;
        end
        // Signed division truncates toward zero
        quo = (prod_t'(num) <<< `FRAC_BITS) / prod_t'(den);
        if (quo > prod_t'(`FIX_MAX)) begin
            return `FIX_MAX;
        end else if (quo < prod_t'(`FIX_MIN)) begin
            return `FIX_MIN;
        end
        return fix_t'(quo);
    endfunction

endpackage

// File: bradford_adapt.sv
`timescale 1ns/10ps

module bradford_adapt (
    input  logic           clk,
    input  logic           rst_n,

    // Ambient white point
    input  brad_pkg::fix_t ambient_x,
    input  brad_pkg::fix_t ambient_y,
    input  brad_pkg::fix_t ambient_z,

    // Reference white point
    input  brad_pkg::fix_t ref_x,
    input  brad_pkg::fix_t ref_y,
    input  brad_pkg::fix_t ref_z,

    input  logic           xyz_valid,

    // Compensation matrix, four cycles after the strobe
    output brad_pkg::mat_t comp_matrix,
    output logic           matrix_valid
);

    // ------------------------------------------------------------------
    // Cone-space links between the pipeline stages
    // ------------------------------------------------------------------
    lms_if amb_lms ();
    lms_if ref_lms ();
    lms_if gain_lms ();

    // Ambient and reference sides run side by side
    cone_transform amb_cone_i (
        .clk   (clk),
        .rst_n (rst_n),
        .x     (ambient_x),
        .y     (ambient_y),
        .z     (ambient_z),
        .start (xyz_valid),
        .cone  (amb_lms.src)
    );

    cone_transform ref_cone_i (
        .clk   (clk),
        .rst_n (rst_n),
        .x     (ref_x),
        .y     (ref_y),
        .z     (ref_z),
        .start (xyz_valid),
        .cone  (ref_lms.src)
    );

    gain_divider gain_div_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .amb      (amb_lms.dst),
        .ref_cone (ref_lms.dst),
        .gain     (gain_lms.src)
    );

    matrix_composer composer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .gain         (gain_lms.dst),
        .comp_matrix  (comp_matrix),
        .matrix_valid (matrix_valid)
    );

endmodule

// File: cone_transform.sv
`timescale 1ns/10ps
`include "brad_defs.svh"

module cone_transform (
    input  logic         clk,
    input  logic         rst_n,
    input  brad_pkg::fix_t x,
    input  brad_pkg::fix_t y,
    input  brad_pkg::fix_t z,
    input  logic         start,
    lms_if.src           cone
);
    import brad_pkg::*;

    // Forward Bradford rows
    localparam fix_t M_FWD [3][3] = '{
        '{`BRAD_00, `BRAD_01, `BRAD_02},
        '{`BRAD_10, `BRAD_11, `BRAD_12},
        '{`BRAD_20, `BRAD_21, `BRAD_22}
    };

    fix_t row_sum [3];
    fix_t cone_c  [3];

    // ------------------------------------------------------------------
    // XYZ to LMS with one row per cone
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            // 32-bit sum wraps before the clamp
            row_sum[i] = fix_mul(M_FWD[i][0], x)
                       + fix_mul(M_FWD[i][1], y)
                       + fix_mul(M_FWD[i][2], z);
            cone_c[i] = fix_clamp(prod_t'(row_sum[i]));
        end
    end

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cone.valid <= 1'b0;
        end else begin
            cone.valid <= start;
        end
    end

    // Payload only loads on a strobe
    always_ff @(posedge clk) begin
        if (start) begin
            cone.l <= cone_c[0];
            cone.m <= cone_c[1];
            cone.s <= cone_c[2];
        end
    end

    // One cycle from strobe to a known cone triple
    a_cone_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |=> cone.valid && !$isunknown({cone.l, cone.m, cone.s})
    );

endmodule

// File: gain_divider.sv
`timescale 1ns/10ps

module gain_divider (
    input  logic clk,
    input  logic rst_n,
    lms_if.dst   amb,
    lms_if.dst   ref_cone,
    lms_if.src   gain
);
    import brad_pkg::*;

    fix_t amb_c  [3];
    fix_t ref_c  [3];
    fix_t quot   [3];

    assign amb_c[0] = amb.l;
    assign amb_c[1] = amb.m;
    assign amb_c[2] = amb.s;

    assign ref_c[0] = ref_cone.l;
    assign ref_c[1] = ref_cone.m;
    assign ref_c[2] = ref_cone.s;

    // ------------------------------------------------------------------
    // Von Kries gains, reference cone over ambient cone
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            quot[i] = fix_div(ref_c[i], amb_c[i]);
        end
    end

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------

    // Ambient strobe alone drives the stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gain.valid <= 1'b0;
        end else begin
            gain.valid <= amb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (amb.valid) begin
            gain.l <= quot[0];
            gain.m <= quot[1];
            gain.s <= quot[2];
        end
    end

    // Both cone transforms share one input strobe
    a_cone_sync: assert property (
        @(posedge clk) disable iff (!rst_n)
        amb.valid == ref_cone.valid
    );

endmodule

// File: lms_if.sv
`timescale 1ns/10ps

interface lms_if;
    import brad_pkg::*;

    // One cone-space triple, meaningful while valid is high
    fix_t l;
    fix_t m;
    fix_t s;
    logic valid;

    modport src (
        output l,
        output m,
        output s,
        output valid
    );

    modport dst (
        input l,
        input m,
        input s,
        input valid
    );

endinterface

// File: matrix_composer.sv
`timescale 1ns/10ps
`include "brad_defs.svh"

module matrix_composer (
    input  logic           clk,
    input  logic           rst_n,
    lms_if.dst             gain,
    output brad_pkg::mat_t comp_matrix,
    output logic           matrix_valid
);
    import brad_pkg::*;

    // Forward Bradford rows, scaled by the gains in stage 1
    localparam fix_t M_FWD [3][3] = '{
        '{`BRAD_00, `BRAD_01, `BRAD_02},
        '{`BRAD_10, `BRAD_11, `BRAD_12},
        '{`BRAD_20, `BRAD_21, `BRAD_22}
    };

    // Inverse Bradford rows, applied in stage 2
    localparam fix_t M_INV [3][3] = '{
        '{`BRAD_INV_00, `BRAD_INV_01, `BRAD_INV_02},
        '{`BRAD_INV_10, `BRAD_INV_11, `BRAD_INV_12},
        '{`BRAD_INV_20, `BRAD_INV_21, `BRAD_INV_22}
    };

    fix_t  g        [3];
    fix_t  scaled_c [3][3];
    fix_t  scaled   [3][3];
    logic  s1_valid;
    prod_t acc      [3][3];
    fix_t  elem     [3][3];

    assign g[0] = gain.l;
    assign g[1] = gain.m;
    assign g[2] = gain.s;

    // ------------------------------------------------------------------
    // Stage 1: diag(gain) x forward matrix
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                scaled_c[i][j] = fix_mul(g[i], M_FWD[i][j]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= gain.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (gain.valid) begin
            scaled <= scaled_c;
        end
    end

    // ------------------------------------------------------------------
    // Stage 2: inverse matrix x scaled matrix, clamped to +/-2.0
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                // Wide sum, so three near-limit terms cannot wrap
                acc[i][j] = '0;
                for (int k = 0; k < 3; k++) begin
                    acc[i][j] = acc[i][j] + prod_t'(fix_mul(M_INV[i][k], scaled[k][j]));
                end
                elem[i][j] = fix_clamp(acc[i][j]);
            end
        end
    end

    // Matrix holds its value between results
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            comp_matrix  <= '0;
            matrix_valid <= 1'b0;
        end else begin
            matrix_valid <= s1_valid;
            if (s1_valid) begin
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        comp_matrix[(3*i+j)*`FIX_W +: `FIX_W] <= elem[i][j];
                    end
                end
            end
        end
    end

    // Every published element lies within the clamp range
    for (genvar e = 0; e < 9; e++) begin : g_range_chk
        a_elem_range: assert property (
            @(posedge clk) disable iff (!rst_n)
            matrix_valid |->
                (fix_t'(comp_matrix[e*`FIX_W +: `FIX_W]) <= `FIX_CLAMP) &&
                (fix_t'(comp_matrix[e*`FIX_W +: `FIX_W]) >= -`FIX_CLAMP)
        );
    end

endmodule

// File: tb_bradford.sv
`timescale 1ns/10ps
`include "brad_defs.svh"

module tb_bradford;
    import brad_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int LATENCY    = 4;
    localparam int MAX_CYCLES = 2000;

    // White points in Q16.16
    localparam int D65_X = 32'h0000_F352;
    localparam int D65_Y = 32'h0001_0000;
    localparam int D65_Z = 32'h0001_16BD;
    localparam int ILA_X = 32'h0001_1937;
    localparam int ILA_Z = 32'h0000_5B19;
    localparam int D50_X = 32'h0000_F6D7;
    localparam int D50_Z = 32'h0000_D341;
    localparam int TEN   = 32'h000A_0000;

    localparam int FWD [3][3] = '{
        '{`BRAD_00, `BRAD_01, `BRAD_02},
        '{`BRAD_10, `BRAD_11, `BRAD_12},
        '{`BRAD_20, `BRAD_21, `BRAD_22}
    };

    localparam int INV [3][3] = '{
        '{`BRAD_INV_00, `BRAD_INV_01, `BRAD_INV_02},
        '{`BRAD_INV_10, `BRAD_INV_11, `BRAD_INV_12},
        '{`BRAD_INV_20, `BRAD_INV_21, `BRAD_INV_22}
    };

    logic   clk;
    logic   rst_n;
    fix_t   ambient_x;
    fix_t   ambient_y;
    fix_t   ambient_z;
    fix_t   ref_x;
    fix_t   ref_y;
    fix_t   ref_z;
    logic   xyz_valid;
    mat_t   comp_matrix;
    logic   matrix_valid;

    int     cycle  = 0;
    int     checks = 0;
    int     errors = 0;
    integer seed;
    mat_t   exp_q [$];
    int     due_q [$];
    mat_t   last_seen;

    bradford_adapt dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ambient_x    (ambient_x),
        .ambient_y    (ambient_y),
        .ambient_z    (ambient_z),
        .ref_x        (ref_x),
        .ref_y        (ref_y),
        .ref_z        (ref_z),
        .xyz_valid    (xyz_valid),
        .comp_matrix  (comp_matrix),
        .matrix_valid (matrix_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    // Q16.16 product keeps the low word of the shifted 64-bit result
    function automatic int q_mul(input int a, input int b);
        longint p;
        p = longint'(a) * longint'(b);
        return int'(p >>> 16);
    endfunction

    function automatic int limit_two(input longint v);
        longint lim;
        lim = `FIX_CLAMP;
        if (v > lim) begin
            return int'(lim);
        end else if (v < -lim) begin
            return int'(-lim);
        end
        return int'(v);
    endfunction

    function automatic int safe_div(input int num, input int den);
        longint q;
        if (den > -`DIV_MIN && den < `DIV_MIN) begin
            if (num == 0) begin
                return 0;
            end
            return ((num < 0) == (den < 0)) ? 32'sh7FFF_FFFF : 32'sh8000_0000;
        end
        q = (longint'(num) * 65536) / longint'(den);
        if (q > 64'sh7FFF_FFFF) begin
            return 32'sh7FFF_FFFF;
        end else if (q < -64'sh8000_0000) begin
            return 32'sh8000_0000;
        end
        return int'(q);
    endfunction

    function automatic mat_t model_matrix(input int ax, input int ay, input int az,
                                          input int rx, input int ry, input int rz);
        int     amb_c [3];
        int     ref_c [3];
        int     g     [3];
        int     sc    [3][3];
        int     row;
        longint acc;
        mat_t   m;
        for (int i = 0; i < 3; i++) begin
            // Cone sums wrap at 32 bits before the clamp
            row = q_mul(FWD[i][0], ax) + q_mul(FWD[i][1], ay) + q_mul(FWD[i][2], az);
            amb_c[i] = limit_two(longint'(row));
            row = q_mul(FWD[i][0], rx) + q_mul(FWD[i][1], ry) + q_mul(FWD[i][2], rz);
            ref_c[i] = limit_two(longint'(row));
            g[i] = safe_div(ref_c[i], amb_c[i]);
        end
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                sc[i][j] = q_mul(g[i], FWD[i][j]);
            end
        end
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                acc = 0;
                for (int k = 0; k < 3; k++) begin
                    acc = acc + longint'(q_mul(INV[i][k], sc[k][j]));
                end
                m[(3*i+j)*32 +: 32] = limit_two(acc);
            end
        end
        return m;
    endfunction

    function automatic int matrix_elem(input mat_t m, input int idx);
        return int'(m[idx*32 +: 32]);
    endfunction

    // Roughly 0.19 to 1.19 per channel
    function automatic int rand_white();
        int r;
        r = $random(seed);
        return (r & 32'hFFFF) + 32'h3000;
    endfunction

    // ----------------------------------------------------------------------
    // Result monitor against the expected queue
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (due_q.size() > 0 && due_q[0] == cycle + 1) begin
                if (!matrix_valid) begin
                    $display("Result due at cycle %0d did not arrive (time %0t)",
                             cycle + 1, $time);
                    errors++;
                end else begin
                    checks++;
                    if (comp_matrix !== exp_q[0]) begin
                        $display("CHECK FAILED at %0t: matrix %h, expected %h",
                                 $time, comp_matrix, exp_q[0]);
                        errors++;
                    end
                end
                last_seen = comp_matrix;
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end else if (matrix_valid) begin
                $display("Unexpected matrix_valid pulse at time %0t", $time);
                errors++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus tasks
    // ----------------------------------------------------------------------
    task automatic apply_white(input int ax, input int ay, input int az,
                               input int rx, input int ry, input int rz);
        @(posedge clk);
        #1;
        ambient_x = ax;
        ambient_y = ay;
        ambient_z = az;
        ref_x     = rx;
        ref_y     = ry;
        ref_z     = rz;
        xyz_valid = 1'b1;
        exp_q.push_back(model_matrix(ax, ay, az, rx, ry, rz));
        // Strobe is taken at the next edge
        due_q.push_back(cycle + 1 + LATENCY);
    endtask

    task automatic end_strobe();
        @(posedge clk);
        #1;
        xyz_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (due_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic send_single(input int ax, input int ay, input int az,
                               input int rx, input int ry, input int rz);
        apply_white(ax, ay, az, rx, ry, rz);
        end_strobe();
        wait_drain();
    endtask

    task automatic check_range();
        int v;
        for (int e = 0; e < 9; e++) begin
            v = matrix_elem(last_seen, e);
            checks++;
            if (v > `FIX_CLAMP || v < -`FIX_CLAMP) begin
                $display("CHECK FAILED at %0t: element %0d = %h out of range", $time, e, v);
                errors++;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic reset_idle();
        repeat (8) begin
            @(negedge clk);
            checks++;
            if (matrix_valid !== 1'b0 || comp_matrix !== '0) begin
                $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
                errors++;
            end
        end
    endtask

    task automatic equal_white_identity();
        int v;
        int want;
        send_single(D65_X, D65_Y, D65_Z, D65_X, D65_Y, D65_Z);
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                v    = matrix_elem(last_seen, 3*i+j);
                want = (i == j) ? 32'h0001_0000 : 0;
                checks++;
                if (v - want > 32'sh100 || want - v > 32'sh100) begin
                    $display("CHECK FAILED at %0t: element %0d%0d = %h, not near identity",
                             $time, i, j, v);
                    errors++;
                end
            end
        end
    endtask

    task automatic directed_pairs();
        send_single(ILA_X, D65_Y, ILA_Z, D65_X, D65_Y, D65_Z);
        send_single(D50_X, D65_Y, D50_Z, D65_X, D65_Y, D65_Z);
    endtask

    task automatic guard_and_clamp();
        // Zero ambient cones hit the divide guard
        send_single(0, 0, 0, D65_X, D65_Y, D65_Z);
        check_range();
        send_single(TEN, TEN, TEN, D65_X, D65_Y, D65_Z);
        check_range();
    endtask

    task automatic pipelined_stream();
        for (int n = 0; n < 8; n++) begin
            apply_white(rand_white(), rand_white(), rand_white(),
                        rand_white(), rand_white(), rand_white());
        end
        end_strobe();
        wait_drain();
    endtask

    initial begin
        seed      = 32'h8cdb;
        rst_n     = 1'b0;
        xyz_valid = 1'b0;
        ambient_x = '0;
        ambient_y = '0;
        ambient_z = '0;
        ref_x     = '0;
        ref_y     = '0;
        ref_z     = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_idle();
        equal_white_identity();
        directed_pairs();
        guard_and_clamp();
        pipelined_stream();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
brad_pkg.sv
lms_if.sv
cone_transform.sv
gain_divider.sv
matrix_composer.sv
bradford_adapt.sv
tb_bradford.sv
